// ==== usb_line_pkg.sv ====
// USB full-speed line level definitions
// decoded D+/D- pair and the fixed bit timing of the 48 MHz receiver

package usb_line_pkg;

  // {D+, D-} as seen by the receiver
  typedef enum logic [1:0] {
    se0 = 2'b00,  // single ended zero
    k   = 2'b01,  // full-speed K
    j   = 2'b10,  // full-speed J, idle
    se1 = 2'b11   // illegal
  } line_state_t;

  // 48 MHz clock over 12 Mbit/s
  localparam int clks_per_bit = 4;

  // clocks from a detected edge to the sample point of that cell
  localparam int sample_delay = clks_per_bit / 2;

endpackage

// ==== usb_pkt_pkg.sv ====
// USB packet level definitions
// PID codes, receiver events, output items, packet status and CRC residues

package usb_pkt_pkg;

  // lower nibble of the PID byte
  typedef enum logic [3:0] {
    pid_out   = 4'b0001,
    pid_in    = 4'b1001,
    pid_sof   = 4'b0101,
    pid_setup = 4'b1101,
    pid_data0 = 4'b0011,
    pid_data1 = 4'b1011,
    pid_ack   = 4'b0010,
    pid_nak   = 4'b1010,
    pid_stall = 4'b1110
  } pid_t;

  typedef enum logic [1:0] {
    ev_byte,  // one received byte in data
    ev_eop,   // clean end of packet
    ev_err    // broken line, packet aborted
  } evt_kind_t;

  typedef struct packed {
    evt_kind_t  kind;
    logic [7:0] data;
  } rx_evt_t;

  typedef enum logic [2:0] {
    st_ok,
    st_bad_pid,
    st_bad_len,
    st_bad_crc,
    st_line_err,
    st_overflow
  } pkt_status_t;

  typedef struct packed {
    logic        last;    // closing status item
    logic [7:0]  data;    // zero when last
    pkt_status_t status;  // valid when last
  } item_t;

  // register contents after data plus a correct CRC field
  localparam logic [4:0]  crc5_residue  = 5'b01100;
  localparam logic [15:0] crc16_residue = 16'h800d;

endpackage

// ==== usb_line_rx.sv ====
// USB full-speed line receiver
// synchronizes D+/D-, finds SYNC, decodes NRZI, drops stuffed bits and
// reports bytes, end of packet and line errors as one-cycle events

module usb_line_rx (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 usb_p,
  input  logic                 usb_n,
  output usb_pkt_pkg::rx_evt_t evt,
  output logic                 evt_valid
);

  import usb_line_pkg::*;
  import usb_pkt_pkg::*;

  localparam int tick_w = $clog2(clks_per_bit);

  typedef enum logic [2:0] {
    s_reset,  // wait for J
    s_idle,   // wait for the first K of SYNC
    s_sync,
    s_data,
    s_eop,    // counting SE0 cells
    s_error   // wait for SE0
  } rx_state_t;

  logic [2:0]        dp;  // D+ synchronizer
  logic [2:0]        dn;  // D- synchronizer
  line_state_t       line;
  logic              agree;
  logic              line_bad;
  logic              sample;
  logic              nrzi_bit;
  line_state_t       prev;     // symbol of the previous cell
  rx_state_t         state;
  logic [tick_w-1:0] tick;
  logic [2:0]        bit_cnt;  // data bits, or SE0 cells in s_eop
  logic [2:0]        ones;     // run of ones for unstuffing
  logic [7:0]        shift;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dp <= '0;
      dn <= '0;
    end
    else
    begin
      dp <= {dp[1:0], usb_p};
      dn <= {dn[1:0], usb_n};
    end
  end

  assign line     = line_state_t'({dp[2], dn[2]});
  assign agree    = (dp[2] == dp[1]) && (dn[2] == dn[1]);  // two samples alike
  assign line_bad = !agree || (line == se1);
  assign sample   = (tick == '0);                          // once per cell
  assign nrzi_bit = (line == prev);                        // no transition is a one

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= s_reset;
      prev      <= j;
      tick      <= '0;
      bit_cnt   <= '0;
      ones      <= '0;
      shift     <= '0;
      evt       <= '0;
      evt_valid <= 1'b0;
    end
    else
    begin
      evt_valid <= 1'b0;
      tick      <= tick + 1'b1;
      case (state)
        s_reset:
          if (agree && line == j)
            state <= s_idle;
        s_idle:
          if (agree && line == k)
          begin
            state <= s_sync;
            prev  <= j;
            tick  <= tick_w'(clks_per_bit + 1 - sample_delay);  // sample mid cell
          end
          else if (agree && line == se0)
            state <= s_reset;
        s_sync:
          if (sample)
          begin
            if (line_bad || line == se0)
              state <= s_error;  // no packet yet, nothing to report
            else
            begin
              prev <= line;
              if (nrzi_bit)  // closing KK of SYNC
              begin
                state   <= s_data;
                bit_cnt <= '0;
                ones    <= 3'd1;
              end
            end
          end
        s_data:
          if (sample)
          begin
            if (line_bad || (line == se0 && bit_cnt != '0))
            begin
              evt_valid <= 1'b1;
              evt.kind  <= ev_err;
              evt.data  <= '0;
              state     <= s_error;
            end
            else if (line == se0)
            begin
              state   <= s_eop;
              bit_cnt <= 3'd1;
            end
            else
            begin
              prev <= line;
              if (ones == 3'd6)
                ones <= '0;  // stuffed bit
              else
              begin
                shift   <= {nrzi_bit, shift[7:1]};  // LSB first
                ones    <= nrzi_bit ? ones + 1'b1 : '0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7)
                begin
                  evt_valid <= 1'b1;
                  evt.kind  <= ev_byte;
                  evt.data  <= {nrzi_bit, shift[7:1]};
                end
              end
            end
          end
        s_eop:
          if (sample)
          begin
            if (agree && line == se0)
              bit_cnt <= 3'd2;
            else if (agree && line == j && bit_cnt == 3'd2)
            begin
              evt_valid <= 1'b1;
              evt.kind  <= ev_eop;
              evt.data  <= '0;
              state     <= s_idle;
            end
            else
            begin
              evt_valid <= 1'b1;
              evt.kind  <= ev_err;
              evt.data  <= '0;
              state     <= s_error;
            end
          end
        s_error:
          if (agree && line == se0)
            state <= s_reset;
        default:
          state <= s_error;
      endcase
    end
  end

endmodule

// ==== usb_pkt_check.sv ====
// USB packet checker
// validates PID, length and CRC5/CRC16 of each received packet, forwards
// every byte and closes each packet with one status item

module usb_pkt_check (
  input  logic                 clk,
  input  logic                 arst_n,
  input  usb_pkt_pkg::rx_evt_t evt,
  input  logic                 evt_valid,
  output usb_pkt_pkg::item_t   item,
  output logic                 item_valid
);

  import usb_pkt_pkg::*;

  pid_t        pid_q;
  logic        pid_good_q;  // upper nibble is complement of lower
  logic [2:0]  cnt_q;       // bytes so far, saturating
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic        len_ok;
  logic        crc_ok;
  logic        pid_known;
  pkt_status_t status;

  // bits enter LSB first, as on the wire
  function automatic logic [4:0] crc5_step(logic [4:0] crc, logic [7:0] b);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++)
      c = {c[3:0], 1'b0} ^ ((b[i] ^ c[4]) ? 5'h05 : 5'h00);
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(logic [15:0] crc, logic [7:0] b);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++)
      c = {c[14:0], 1'b0} ^ ((b[i] ^ c[15]) ? 16'h8005 : 16'h0000);
    return c;
  endfunction

  always_comb
  begin
    len_ok    = 1'b0;
    crc_ok    = 1'b1;
    pid_known = 1'b1;
    case (pid_q)
      pid_out, pid_in, pid_sof, pid_setup:
      begin
        len_ok = (cnt_q == 3'd3);
        crc_ok = (crc5_q == crc5_residue);
      end
      pid_data0, pid_data1:
      begin
        len_ok = (cnt_q >= 3'd3);  // PID plus CRC16 at least
        crc_ok = (crc16_q == crc16_residue);
      end
      pid_ack, pid_nak, pid_stall:
        len_ok = (cnt_q == 3'd1);
      default:
        pid_known = 1'b0;
    endcase

    if (evt.kind == ev_err)
      status = st_line_err;
    else if (!pid_good_q || !pid_known)
      status = st_bad_pid;
    else if (!len_ok)
      status = st_bad_len;
    else if (!crc_ok)
      status = st_bad_crc;
    else
      status = st_ok;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pid_q      <= pid_t'(4'h0);
      pid_good_q <= 1'b0;
      cnt_q      <= '0;
      crc5_q     <= '1;
      crc16_q    <= '1;
      item       <= '0;
      item_valid <= 1'b0;
    end
    else
    begin
      item_valid <= evt_valid;  // one item per event
      if (evt_valid)
      begin
        if (evt.kind == ev_byte)
        begin
          item.last   <= 1'b0;
          item.data   <= evt.data;
          item.status <= st_ok;
          if (cnt_q != 3'd7)
            cnt_q <= cnt_q + 1'b1;
          if (cnt_q == '0)
          begin
            pid_q      <= pid_t'(evt.data[3:0]);
            pid_good_q <= (evt.data[7:4] == ~evt.data[3:0]);
            crc5_q     <= '1;
            crc16_q    <= '1;
          end
          else
          begin
            crc5_q  <= crc5_step(crc5_q, evt.data);
            crc16_q <= crc16_step(crc16_q, evt.data);
          end
        end
        else
        begin
          item.last   <= 1'b1;
          item.data   <= '0;
          item.status <= status;
          cnt_q       <= '0;  // ready for next packet
          pid_good_q  <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== usb_pkt_out.sv ====
// Output buffer with four-phase req/ack handshake
// byte slots plus one slot held back for the closing status item

module usb_pkt_out #(
  parameter int fifo_depth = 8
) (
  input  logic               clk,
  input  logic               arst_n,
  input  usb_pkt_pkg::item_t item,
  input  logic               item_valid,
  output usb_pkt_pkg::item_t out_item,
  output logic               req,
  input  logic               ack
);

  import usb_pkt_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth + 1);
  localparam int cnt_w = $clog2(fifo_depth + 2);

  typedef enum logic [1:0] {s_idle, s_wait_ack, s_wait_release} hs_state_t;

  item_t            mem [0:fifo_depth];
  item_t            wr_item;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             ovf_q;  // bytes lost in current packet
  logic             push;
  logic             pop;
  hs_state_t        hs;

  function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
    return (p == ptr_w'(fifo_depth)) ? '0 : p + 1'b1;
  endfunction

  always_comb
  begin
    wr_item = item;
    if (item.last && ovf_q)
      wr_item.status = st_overflow;  // overrides any other outcome
  end

  assign push = item_valid && (item.last ? (count != cnt_w'(fifo_depth + 1))
                                         : (count < cnt_w'(fifo_depth)));
  assign pop      = (hs == s_wait_ack) && ack;
  assign out_item = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= wr_item;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf_q  <= 1'b0;
      hs     <= s_idle;
      req    <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + cnt_w'(push) - cnt_w'(pop);

      if (item_valid && item.last)
        ovf_q <= 1'b0;
      else if (item_valid && !push)
        ovf_q <= 1'b1;  // byte dropped

      case (hs)
        s_idle:
          if (count != '0 && !ack)
          begin
            req <= 1'b1;
            hs  <= s_wait_ack;
          end
        s_wait_ack:
          if (ack)
          begin
            req <= 1'b0;
            hs  <= s_wait_release;
          end
        s_wait_release:
          if (!ack)
            hs <= s_idle;
        default:
          hs <= s_idle;
      endcase
    end
  end

endmodule

// ==== usb_rx_top.sv ====
// USB full-speed receive path
// line receiver, packet checker and handshaked output buffer

module usb_rx_top #(
  parameter int fifo_depth = 8
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               usb_p,
  input  logic               usb_n,
  output usb_pkt_pkg::item_t out_item,
  output logic               req,
  input  logic               ack
);

  import usb_pkt_pkg::*;

  rx_evt_t evt;
  logic    evt_valid;
  item_t   item;
  logic    item_valid;

  usb_line_rx line_rx_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .usb_p     (usb_p),
    .usb_n     (usb_n),
    .evt       (evt),
    .evt_valid (evt_valid)
  );

  usb_pkt_check pkt_check_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .evt        (evt),
    .evt_valid  (evt_valid),
    .item       (item),
    .item_valid (item_valid)
  );

  usb_pkt_out #(
    .fifo_depth (fifo_depth)
  ) pkt_out_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .item       (item),
    .item_valid (item_valid),
    .out_item   (out_item),
    .req        (req),
    .ack        (ack)
  );

endmodule

// ==== usb_rx_sva.sv ====
// Assertions on the receive path output handshake
// req/ack ordering, item stability and a shadow count of buffered items

module usb_rx_sva #(
  parameter int fifo_depth = 8
) (
  input logic               clk,
  input logic               arst_n,
  input usb_pkt_pkg::item_t item,
  input logic               item_valid,
  input usb_pkt_pkg::item_t out_item,
  input logic               req,
  input logic               ack
);

  import usb_pkt_pkg::*;

  localparam int fill_w = $clog2(fifo_depth + 2);

  logic [fill_w-1:0] fill;  // items held in the buffer
  logic              wr;
  logic              rd;

  assign wr = item_valid && (item.last ? (fill != fill_w'(fifo_depth + 1))
                                       : (fill < fill_w'(fifo_depth)));
  assign rd = req && ack;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      fill <= '0;
    else
      fill <= fill + fill_w'(wr) - fill_w'(rd);
  end

  req_rise_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(req) |-> !$past(ack))
    else $error("req rose while ack was high");

  item_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (req && !ack) |=> $stable(out_item))
    else $error("out_item changed while waiting for ack");

  req_fall_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(req) |-> $past(ack))
    else $error("req fell without ack");

  req_has_item: assert property (@(posedge clk) disable iff (!arst_n)
    req |-> (fill != '0))
    else $error("req high with an empty buffer");

endmodule

bind usb_rx_top usb_rx_sva #(
  .fifo_depth (fifo_depth)
) rx_sva_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .item       (item),
  .item_valid (item_valid),
  .out_item   (out_item),
  .req        (req),
  .ack        (ack)
);

// ==== tb_usb_rx.sv ====
// Testbench for the USB full-speed receive path
// encodes packets onto D+/D-, consumes items over req/ack and checks
// them against the expected bytes and packet status

module tb_usb_rx;

  import usb_line_pkg::*;
  import usb_pkt_pkg::*;

  typedef logic [7:0] byte_q_t [$];

  localparam int fifo_depth      = 8;
  localparam int idle_cells      = 3;   // J cells after each EOP
  localparam int n_packets       = 10;
  localparam int n_bytes         = 45;
  localparam int total_cells     = n_bytes * 10 + n_packets * (8 + 3 + idle_cells);
  localparam int watchdog_cycles = total_cells * clks_per_bit * 2 + 5000;
  localparam int item_wait       = 400;  // cycles allowed for all items of one check

  logic        clk = 1'b0;
  logic        arst_n;
  logic        usb_p;
  logic        usb_n;
  item_t       out_item;
  logic        req;
  logic        ack;
  logic        hold_ack;                  // consumer stalls while set
  line_state_t level;                     // current NRZI line level
  int          ones;                      // run of ones for stuffing
  logic [31:0] lfsr_state = 32'hea898df4;
  item_t       rx_q [$];
  item_t       exp_q [$];
  int          mismatch_cnt = 0;
  int          other_cnt = 0;

  usb_rx_top #(
    .fifo_depth (fifo_depth)
  ) dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .usb_p    (usb_p),
    .usb_n    (usb_n),
    .out_item (out_item),
    .req      (req),
    .ack      (ack)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val        = (val << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // x^5 + x^2 + 1 over the 11-bit token field, sent complemented
  function automatic logic [4:0] usb_crc5(input logic [10:0] field);
    logic [4:0] rem;
    logic       fb;
    rem = 5'h1f;
    for (int i = 0; i < 11; i++)
    begin
      fb  = field[i] ^ rem[4];
      rem = {rem[3], rem[2], rem[1] ^ fb, rem[0], fb};
    end
    return ~rem;
  endfunction

  function automatic logic [15:0] usb_crc16(input byte_q_t data);
    logic [15:0] rem;
    logic        fb;
    rem = 16'hffff;
    foreach (data[n])
      for (int i = 0; i < 8; i++)
      begin
        fb  = data[n][i] ^ rem[15];
        rem = {rem[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    return ~rem;
  endfunction

  function automatic byte_q_t token_packet(input logic [7:0] pid, input logic [10:0] field);
    byte_q_t     pkt;
    logic [4:0]  crc;
    logic [15:0] bits;
    crc        = usb_crc5(field);
    bits[10:0] = field;
    for (int i = 0; i < 5; i++)
      bits[11 + i] = crc[4 - i];  // crc msb goes out first
    pkt.push_back(pid);
    pkt.push_back(bits[7:0]);
    pkt.push_back(bits[15:8]);
    return pkt;
  endfunction

  function automatic byte_q_t data_packet(input logic [7:0] pid, input byte_q_t payload,
                                          input logic corrupt);
    byte_q_t     pkt;
    logic [15:0] crc;
    logic [15:0] wire_crc;
    crc = usb_crc16(payload);
    for (int i = 0; i < 16; i++)
      wire_crc[i] = crc[15 - i];
    if (corrupt)
      wire_crc[9] = ~wire_crc[9];
    pkt = payload;
    pkt.push_front(pid);
    pkt.push_back(wire_crc[7:0]);
    pkt.push_back(wire_crc[15:8]);
    return pkt;
  endfunction

  function automatic string item_text(input item_t it);
    return $sformatf("last %0b data %02h status %0d", it.last, it.data, it.status);
  endfunction

  task automatic drive_cell(input line_state_t s);
    @(negedge clk);
    {usb_p, usb_n} = s;
    repeat (clks_per_bit - 1) @(negedge clk);
  endtask

  task automatic send_bit(input logic b);
    if (!b)
      level = (level == j) ? k : j;  // zero is a transition
    drive_cell(level);
  endtask

  task automatic send_data_bit(input logic b);
    send_bit(b);
    ones = b ? ones + 1 : 0;
    if (ones == 6)
    begin
      send_bit(1'b0);
      ones = 0;
    end
  endtask

  // cut_bits below zero sends the whole packet, else SE0 after that many bits
  task automatic send_packet(input byte_q_t bytes, input int cut_bits);
    int sent;
    sent  = 0;
    level = j;
    for (int i = 0; i < 7; i++)
      send_bit(1'b0);
    send_bit(1'b1);
    ones = 1;  // SYNC ends with a one
    foreach (bytes[n])
      for (int b = 0; b < 8; b++)
        if (cut_bits < 0 || sent < cut_bits)
        begin
          send_data_bit(bytes[n][b]);
          sent++;
        end
    drive_cell(se0);
    drive_cell(se0);
    level = j;
    repeat (idle_cells + 1) drive_cell(j);
  endtask

  task automatic expect_bytes(input byte_q_t bytes, input int count);
    item_t it;
    for (int i = 0; i < count; i++)
    begin
      it.last   = 1'b0;
      it.data   = bytes[i];
      it.status = st_ok;
      exp_q.push_back(it);
    end
  endtask

  task automatic expect_status(input pkt_status_t st);
    item_t it;
    it.last   = 1'b1;
    it.data   = 8'h00;
    it.status = st;
    exp_q.push_back(it);
  endtask

  task automatic check_items(input string name);
    int waited;
    waited = 0;
    while (rx_q.size() < exp_q.size() && waited < item_wait)
    begin
      @(negedge clk);
      waited++;
    end
    repeat (20) @(negedge clk);  // let stray items show up
    if (rx_q.size() < exp_q.size())
    begin
      other_cnt++;
      $display("%s: only %0d of %0d items were received", name, rx_q.size(), exp_q.size());
    end
    else if (rx_q.size() > exp_q.size())
    begin
      other_cnt++;
      $display("%s: %0d items received, more than the %0d expected", name, rx_q.size(),
               exp_q.size());
    end
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++)
      if (rx_q[i] !== exp_q[i])
      begin
        mismatch_cnt++;
        $display("Mismatch %s item %0d: expected %s, actual %s", name, i,
                 item_text(exp_q[i]), item_text(rx_q[i]));
      end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic test_handshake();
    byte_q_t pkt;
    pkt.push_back(8'hd2);  // ACK
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_ok);
    check_items("ack_handshake");
  endtask

  task automatic test_stuffing();
    byte_q_t pay;
    byte_q_t pkt;
    pay = {8'h01, 8'hff, 8'hff, 8'h7e};
    pkt = data_packet(8'hc3, pay, 1'b0);
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_ok);
    check_items("data0_stuffing");
    pkt = token_packet(8'he1, 11'h3a5);
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_ok);
    check_items("out_token");
  endtask

  task automatic test_bad_packets();
    byte_q_t pay;
    byte_q_t pkt;
    pay = {8'h10, 8'h20, 8'h30};
    pkt = data_packet(8'h4b, pay, 1'b1);
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_bad_crc);
    check_items("data1_bad_crc");
    pkt = {8'h12};  // nibbles not complementary
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_bad_pid);
    check_items("bad_pid");
    pkt = {8'h69, 8'h05};  // IN one byte short
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_bad_len);
    check_items("short_in_token");
  endtask

  task automatic test_line_error();
    byte_q_t pay;
    byte_q_t pkt;
    pkt = {8'hc3, 8'h55, 8'haa, 8'h0f};
    send_packet(pkt, 27);  // SE0 three bits into the fourth byte
    expect_bytes(pkt, 3);
    expect_status(st_line_err);
    check_items("se0_mid_byte");
    pay = {8'h5a, 8'h33};
    pkt = data_packet(8'hc3, pay, 1'b0);
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_ok);
    check_items("after_line_error");
  endtask

  task automatic test_backpressure();
    byte_q_t pay;
    byte_q_t pkt;
    for (int i = 0; i < 9; i++)
      pay.push_back(8'(i * 29 + 3));
    pkt      = data_packet(8'hc3, pay, 1'b0);  // 12 bytes in all
    hold_ack = 1'b1;
    send_packet(pkt, -1);
    expect_bytes(pkt, fifo_depth);
    expect_status(st_overflow);
    hold_ack = 1'b0;
    check_items("backpressure_overflow");
    pay.delete();
    pay.push_back(8'h99);
    pkt = data_packet(8'h4b, pay, 1'b0);
    send_packet(pkt, -1);
    expect_bytes(pkt, pkt.size());
    expect_status(st_ok);
    check_items("backpressure_recovery");
  endtask

  // four-phase consumer with random ack delay
  initial
  begin : consumer
    int delay;
    ack = 1'b0;
    forever
    begin
      @(negedge clk);
      if (req && !hold_ack)
      begin
        draw_bits(3, delay);
        repeat (delay) @(negedge clk);
        rx_q.push_back(out_item);
        ack = 1'b1;
        while (req)
          @(negedge clk);
        ack = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    usb_p    = 1'b1;  // idle J
    usb_n    = 1'b0;
    arst_n   = 1'b0;
    hold_ack = 1'b0;
    level    = j;
    ones     = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (4) drive_cell(j);
    test_handshake();
    test_stuffing();
    test_bad_packets();
    test_line_error();
    test_backpressure();
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
usb_line_pkg.sv
usb_pkt_pkg.sv
usb_line_rx.sv
usb_pkt_check.sv
usb_pkt_out.sv
usb_rx_top.sv
usb_rx_sva.sv
tb_usb_rx.sv
